// File: replay_pkg.sv
`default_nettype none

package replay_pkg;

    localparam int RTAB_ENTRIES      = 8;
    localparam int ADDR_WIDTH        = 32;
    localparam int LINE_OFFSET_WIDTH = 6;
    localparam int ID_WIDTH          = 8;
    localparam int NLINE_WIDTH       = ADDR_WIDTH - LINE_OFFSET_WIDTH;
    localparam int PTR_WIDTH         = $clog2(RTAB_ENTRIES);

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [NLINE_WIDTH-1:0]  nline_t;
    typedef logic [PTR_WIDTH-1:0]    ptr_t;
    typedef logic [RTAB_ENTRIES-1:0] entry_vec_t;
    typedef logic [ID_WIDTH-1:0]     req_id_t;

    typedef struct packed {
        addr_t   addr;
        logic    is_load;
        req_id_t id;
    } req_t;

    // A set flag keeps the entry from being replayed
    typedef struct packed {
        logic mshr_hit;
        logic mshr_ready;
    } deps_t;

    typedef enum logic {
        POP_IDLE,
        POP_RESOLVE
    } pop_state_e;

    function automatic nline_t get_nline(input addr_t addr);
        return addr[ADDR_WIDTH-1:LINE_OFFSET_WIDTH];
    endfunction

    function automatic ptr_t bv_to_ptr(input entry_vec_t bv);
        ptr_t ptr;
        ptr = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (bv[i]) begin
                ptr = ptr_t'(i);
            end
        end
        return ptr;
    endfunction

    function automatic entry_vec_t ptr_to_bv(input ptr_t ptr);
        entry_vec_t bv;
        bv      = '0;
        bv[ptr] = 1'b1;
        return bv;
    endfunction

endpackage

`default_nettype wire

// File: replay_alloc.sv
`default_nettype none

module replay_alloc (
    input  wire logic                                              alloc_i,
    input  wire replay_pkg::req_t                                  alloc_req_i,
    input  wire replay_pkg::entry_vec_t                            valid_i,
    input  wire replay_pkg::entry_vec_t                            tail_i,
    input  wire replay_pkg::nline_t [replay_pkg::RTAB_ENTRIES-1:0] entry_nline_i,
    input  wire replay_pkg::nline_t                                check_nline_i,
    output logic                                                   check_hit_o,
    output replay_pkg::entry_vec_t                                 alloc_bv_o,
    output replay_pkg::entry_vec_t                                 link_bv_o
);
    import replay_pkg::*;

    entry_vec_t free;
    entry_vec_t first_free;
    entry_vec_t line_match;
    entry_vec_t check_match;
    nline_t     alloc_nline;
    logic       alloc_ok;

    assign free = ~valid_i;

    // Lowest free entry wins, scan from the top so the last write is the lowest
    always_comb begin
        first_free = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (free[i]) begin
                first_free = ptr_to_bv(ptr_t'(i));
            end
        end
    end

    assign alloc_nline = get_nline(alloc_req_i.addr);

    always_comb begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            line_match[i]  = (entry_nline_i[i] == alloc_nline);
            check_match[i] = (entry_nline_i[i] == check_nline_i);
        end
    end

    // An allocation on a full table does nothing
    assign alloc_ok   = alloc_i & (|free);
    assign alloc_bv_o = first_free & {RTAB_ENTRIES{alloc_ok}};

    // Only one valid tail can exist per line, so this is one-hot or zero
    assign link_bv_o = valid_i & tail_i & line_match & {RTAB_ENTRIES{alloc_ok}};

    assign check_hit_o = |(valid_i & check_match);

endmodule

`default_nettype wire

// File: replay_entries.sv
`default_nettype none

module replay_entries (
    input  wire logic                                              clk_i,
    input  wire logic                                              rst_ni,
    input  wire replay_pkg::entry_vec_t                            alloc_bv_i,
    input  wire replay_pkg::entry_vec_t                            link_bv_i,
    input  wire replay_pkg::req_t                                  alloc_req_i,
    input  wire replay_pkg::deps_t                                 alloc_deps_i,
    input  wire replay_pkg::entry_vec_t                            pop_bv_i,
    input  wire replay_pkg::entry_vec_t                            commit_bv_i,
    input  wire replay_pkg::entry_vec_t                            rback_bv_i,
    input  wire replay_pkg::deps_t                                 rback_deps_i,
    input  wire logic                                              refill_i,
    input  wire replay_pkg::nline_t                                refill_nline_i,
    input  wire logic                                              miss_ready_i,
    output replay_pkg::entry_vec_t                                 valid_o,
    output replay_pkg::entry_vec_t                                 tail_o,
    output replay_pkg::entry_vec_t                                 ready_o,
    output replay_pkg::nline_t [replay_pkg::RTAB_ENTRIES-1:0]      entry_nline_o,
    output replay_pkg::req_t [replay_pkg::RTAB_ENTRIES-1:0]        entry_req_o,
    output logic                                                   empty_o,
    output logic                                                   full_o
);
    import replay_pkg::*;

    req_t [RTAB_ENTRIES-1:0] req_q;
    ptr_t [RTAB_ENTRIES-1:0] next_q;

    entry_vec_t valid_q;
    entry_vec_t head_q;
    entry_vec_t tail_q;
    entry_vec_t mshr_hit_q;
    entry_vec_t mshr_ready_q;

    entry_vec_t link_eff;
    entry_vec_t promote;
    entry_vec_t head_set;
    entry_vec_t head_rst;
    entry_vec_t flag_load;
    entry_vec_t hit_set;
    entry_vec_t hit_rst;
    entry_vec_t rdy_set;
    entry_vec_t rdy_rst;
    ptr_t       alloc_ptr;

    // Linking behind an entry that leaves this cycle starts a new list instead
    assign link_eff  = link_bv_i & ~commit_bv_i;
    assign alloc_ptr = bv_to_ptr(alloc_bv_i);

    // A committed entry hands the head over to its successor
    always_comb begin
        promote = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (commit_bv_i[i] && !tail_q[i]) begin
                promote = promote | ptr_to_bv(next_q[i]);
            end
        end
    end

    assign head_set = ((|link_eff) ? '0 : alloc_bv_i) | promote | rback_bv_i;
    assign head_rst = pop_bv_i | commit_bv_i;

    // Allocation and rollback write both flags outright
    assign flag_load = alloc_bv_i | rback_bv_i;
    assign hit_set   = (alloc_bv_i & {RTAB_ENTRIES{alloc_deps_i.mshr_hit}}) |
                       (rback_bv_i & {RTAB_ENTRIES{rback_deps_i.mshr_hit}});
    assign rdy_set   = (alloc_bv_i & {RTAB_ENTRIES{alloc_deps_i.mshr_ready}}) |
                       (rback_bv_i & {RTAB_ENTRIES{rback_deps_i.mshr_ready}});

    always_comb begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            entry_nline_o[i] = get_nline(req_q[i].addr);
            hit_rst[i]       = refill_i & valid_q[i] & (entry_nline_o[i] == refill_nline_i);
        end
    end

    assign rdy_rst = {RTAB_ENTRIES{miss_ready_i}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q      <= '0;
            head_q       <= '0;
            tail_q       <= '0;
            mshr_hit_q   <= '0;
            mshr_ready_q <= '0;
        end else begin
            valid_q      <= (valid_q & ~commit_bv_i) | alloc_bv_i;
            head_q       <= (head_q & ~head_rst) | head_set;
            tail_q       <= (tail_q & ~(link_eff | commit_bv_i)) | alloc_bv_i;
            mshr_hit_q   <= (mshr_hit_q & ~(hit_rst | flag_load)) | hit_set;
            mshr_ready_q <= (mshr_ready_q & ~(rdy_rst | flag_load)) | rdy_set;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (alloc_bv_i[i]) begin
                req_q[i] <= alloc_req_i;
            end
            // Old tail now points at the new entry
            if (link_eff[i]) begin
                next_q[i] <= alloc_ptr;
            end
        end
    end

    assign valid_o     = valid_q;
    assign tail_o      = tail_q;
    assign ready_o     = valid_q & head_q & ~mshr_hit_q & ~mshr_ready_q;
    assign entry_req_o = req_q;
    assign empty_o     = ~(|valid_q);
    assign full_o      = &valid_q;

endmodule

`default_nettype wire

// File: replay_pop.sv
`default_nettype none

module replay_pop (
    input  wire logic                                              clk_i,
    input  wire logic                                              rst_ni,
    input  wire replay_pkg::entry_vec_t                            ready_i,
    input  wire replay_pkg::req_t [replay_pkg::RTAB_ENTRIES-1:0]   entry_req_i,
    input  wire logic                                              pop_ready_i,
    input  wire logic                                              commit_i,
    input  wire logic                                              rback_i,
    output logic                                                   pop_valid_o,
    output replay_pkg::req_t                                       pop_req_o,
    output replay_pkg::ptr_t                                       pop_ptr_o,
    output replay_pkg::entry_vec_t                                 pop_bv_o,
    output replay_pkg::entry_vec_t                                 commit_bv_o,
    output replay_pkg::entry_vec_t                                 rback_bv_o
);
    import replay_pkg::*;

    pop_state_e state_q;
    pop_state_e state_d;
    ptr_t       rr_q;
    ptr_t       held_q;
    ptr_t       gnt_ptr;
    entry_vec_t gnt_bv;
    entry_vec_t held_bv;
    logic       any_ready;
    logic       pop_fire;
    logic       resolve;

    // Round-robin search starting at rr_q
    always_comb begin
        ptr_t idx;
        logic found;
        found   = 1'b0;
        gnt_ptr = '0;
        for (int k = 0; k < RTAB_ENTRIES; k++) begin
            idx = ptr_t'((int'(rr_q) + k) % RTAB_ENTRIES);
            if (!found && ready_i[idx]) begin
                found   = 1'b1;
                gnt_ptr = idx;
            end
        end
    end

    assign any_ready = |ready_i;
    assign gnt_bv    = any_ready ? ptr_to_bv(gnt_ptr) : '0;
    assign resolve   = (state_q == POP_RESOLVE);

    // No new offer while the previous pop awaits its commit or rollback
    assign pop_valid_o = (state_q == POP_IDLE) & any_ready;
    assign pop_fire    = pop_valid_o & pop_ready_i;

    always_comb begin
        pop_req_o = '0;
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            pop_req_o = req_t'(pop_req_o | (entry_req_i[i] & {$bits(req_t){gnt_bv[i]}}));
        end
    end

    assign pop_ptr_o   = gnt_ptr;
    assign held_bv     = ptr_to_bv(held_q);
    assign pop_bv_o    = gnt_bv & {RTAB_ENTRIES{pop_fire}};
    assign commit_bv_o = held_bv & {RTAB_ENTRIES{resolve & commit_i}};
    assign rback_bv_o  = held_bv & {RTAB_ENTRIES{resolve & rback_i}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            POP_IDLE: begin
                if (pop_fire) begin
                    state_d = POP_RESOLVE;
                end
            end
            POP_RESOLVE: begin
                if (commit_i || rback_i) begin
                    state_d = POP_IDLE;
                end
            end
            default: begin
                state_d = POP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= POP_IDLE;
            rr_q    <= '0;
            held_q  <= '0;
        end else begin
            state_q <= state_d;
            // Pointer moves past the winner only on an accepted pop
            if (pop_fire) begin
                rr_q   <= ptr_t'((int'(gnt_ptr) + 1) % RTAB_ENTRIES);
                held_q <= gnt_ptr;
            end
        end
    end

endmodule

`default_nettype wire

// File: replay_table.sv
`default_nettype none

module replay_table (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    output logic                        empty_o,
    output logic                        full_o,
    input  wire replay_pkg::nline_t     check_nline_i,
    output logic                        check_hit_o,
    input  wire logic                   alloc_i,
    input  wire replay_pkg::req_t       alloc_req_i,
    input  wire replay_pkg::deps_t      alloc_deps_i,
    output logic                        pop_valid_o,
    input  wire logic                   pop_ready_i,
    output replay_pkg::req_t            pop_req_o,
    output replay_pkg::ptr_t            pop_ptr_o,
    input  wire logic                   commit_i,
    input  wire logic                   rback_i,
    input  wire replay_pkg::deps_t      rback_deps_i,
    input  wire logic                   refill_i,
    input  wire replay_pkg::nline_t     refill_nline_i,
    input  wire logic                   miss_ready_i
);
    import replay_pkg::*;

    entry_vec_t                alloc_bv;
    entry_vec_t                link_bv;
    entry_vec_t                valid;
    entry_vec_t                tail;
    entry_vec_t                ready;
    entry_vec_t                pop_bv;
    entry_vec_t                commit_bv;
    entry_vec_t                rback_bv;
    nline_t [RTAB_ENTRIES-1:0] entry_nline;
    req_t [RTAB_ENTRIES-1:0]   entry_req;

    // Input side
    replay_alloc u_alloc (
        .alloc_i       (alloc_i),
        .alloc_req_i   (alloc_req_i),
        .valid_i       (valid),
        .tail_i        (tail),
        .entry_nline_i (entry_nline),
        .check_nline_i (check_nline_i),
        .check_hit_o   (check_hit_o),
        .alloc_bv_o    (alloc_bv),
        .link_bv_o     (link_bv)
    );

    // Entry state and linked lists
    replay_entries u_entries (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .alloc_bv_i     (alloc_bv),
        .link_bv_i      (link_bv),
        .alloc_req_i    (alloc_req_i),
        .alloc_deps_i   (alloc_deps_i),
        .pop_bv_i       (pop_bv),
        .commit_bv_i    (commit_bv),
        .rback_bv_i     (rback_bv),
        .rback_deps_i   (rback_deps_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .miss_ready_i   (miss_ready_i),
        .valid_o        (valid),
        .tail_o         (tail),
        .ready_o        (ready),
        .entry_nline_o  (entry_nline),
        .entry_req_o    (entry_req),
        .empty_o        (empty_o),
        .full_o         (full_o)
    );

    // Output side
    replay_pop u_pop (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ready_i     (ready),
        .entry_req_i (entry_req),
        .pop_ready_i (pop_ready_i),
        .commit_i    (commit_i),
        .rback_i     (rback_i),
        .pop_valid_o (pop_valid_o),
        .pop_req_o   (pop_req_o),
        .pop_ptr_o   (pop_ptr_o),
        .pop_bv_o    (pop_bv),
        .commit_bv_o (commit_bv),
        .rback_bv_o  (rback_bv)
    );

endmodule

`default_nettype wire

// File: tb_replay_table.sv
`default_nettype none

module tb_replay_table;
    import replay_pkg::*;

    localparam int    CLK_HALF        = 10;
    localparam int    DRIVE_DELAY     = 2;
    localparam int    RESET_CYCLES    = 3;
    localparam int    POP_WAIT_LIMIT  = 20;
    localparam int    CYCLES_PER_LINE = 24;
    localparam string STIM_FILE       = "replay_stim.txt";

    logic       clk_i = 1'b0;
    logic       rst_ni;
    logic       empty_o;
    logic       full_o;
    nline_t     check_nline_i;
    logic       check_hit_o;
    logic       alloc_i;
    req_t       alloc_req_i;
    deps_t      alloc_deps_i;
    logic       pop_valid_o;
    logic       pop_ready_i;
    req_t       pop_req_o;
    ptr_t       pop_ptr_o;
    logic       commit_i;
    logic       rback_i;
    deps_t      rback_deps_i;
    logic       refill_i;
    nline_t     refill_nline_i;
    logic       miss_ready_i;

    int cycles      = 0;
    int cycle_limit = 0;

    // Entries the table should hold, with the request written to each
    entry_vec_t slot_busy;
    req_t       slot_req [RTAB_ENTRIES];

    replay_table UUT (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .empty_o        (empty_o),
        .full_o         (full_o),
        .check_nline_i  (check_nline_i),
        .check_hit_o    (check_hit_o),
        .alloc_i        (alloc_i),
        .alloc_req_i    (alloc_req_i),
        .alloc_deps_i   (alloc_deps_i),
        .pop_valid_o    (pop_valid_o),
        .pop_ready_i    (pop_ready_i),
        .pop_req_o      (pop_req_o),
        .pop_ptr_o      (pop_ptr_o),
        .commit_i       (commit_i),
        .rback_i        (rback_i),
        .rback_deps_i   (rback_deps_i),
        .refill_i       (refill_i),
        .refill_nline_i (refill_nline_i),
        .miss_ready_i   (miss_ready_i)
    );

    always #CLK_HALF clk_i = ~clk_i;

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
            stop_on_error();
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_on_error();
        end
    endtask

    // Inputs change a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    function automatic bit is_command(input string line);
        byte c;
        if (line.len() == 0) begin
            return 1'b0;
        end
        c = line.getc(0);
        return (c >= "A") && (c <= "Z");
    endfunction

    // A new request takes the lowest free entry
    function automatic int lowest_free_slot();
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (!slot_busy[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int slot_of_id(input logic [31:0] id);
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (slot_busy[i] && 32'(slot_req[i].id) == id) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic alloc_request(input logic [31:0] addr, input logic [31:0] id,
                                 input logic [31:0] hit, input logic [31:0] rdy);
        int slot;
        slot = lowest_free_slot();
        if (slot < 0) begin
            $display("Id 0x%0h was allocated on a full table", id);
            stop_on_error();
        end
        alloc_i                 = 1'b1;
        alloc_req_i.addr        = addr;
        // Loads and stores alternate with the id
        alloc_req_i.is_load     = id[0];
        alloc_req_i.id          = id[ID_WIDTH-1:0];
        alloc_deps_i.mshr_hit   = hit[0];
        alloc_deps_i.mshr_ready = rdy[0];
        slot_busy[slot]         = 1'b1;
        slot_req[slot]          = alloc_req_i;
        next_cycle();
        alloc_i = 1'b0;
    endtask

    // Mode 0 commits the popped entry, mode 1 rolls it back with new flags
    task automatic pop_and_resolve(input logic [31:0] id, input logic [31:0] mode,
                                   input logic [31:0] hit, input logic [31:0] rdy);
        int waited;
        int slot;
        slot = slot_of_id(id);
        if (slot < 0) begin
            $display("Id 0x%0h is not waiting in the table", id);
            stop_on_error();
        end
        waited      = 0;
        pop_ready_i = 1'b1;
        @(negedge clk_i);
        while (!pop_valid_o) begin
            if (waited == POP_WAIT_LIMIT) begin
                $display("Id 0x%0h was not offered within %0d cycles", id, POP_WAIT_LIMIT);
                stop_on_error();
            end
            waited++;
            next_cycle();
            @(negedge clk_i);
        end
        check_value("pop_req_o.id", 32'(pop_req_o.id), id);
        check_value("pop_ptr_o", 32'(pop_ptr_o), 32'(slot));
        check_value("pop_req_o.addr", 32'(pop_req_o.addr), 32'(slot_req[slot].addr));
        check_value("pop_req_o.is_load", 32'(pop_req_o.is_load),
                    32'(slot_req[slot].is_load));
        next_cycle();
        pop_ready_i = 1'b0;
        if (mode[0]) begin
            rback_i                 = 1'b1;
            rback_deps_i.mshr_hit   = hit[0];
            rback_deps_i.mshr_ready = rdy[0];
        end else begin
            commit_i        = 1'b1;
            slot_busy[slot] = 1'b0;
        end
        // Nothing may be offered in the resolve cycle
        @(negedge clk_i);
        check_value("pop_valid_o", 32'(pop_valid_o), 32'h0);
        next_cycle();
        commit_i     = 1'b0;
        rback_i      = 1'b0;
        rback_deps_i = '0;
    endtask

    task automatic refill_line(input logic [31:0] nline);
        refill_i       = 1'b1;
        refill_nline_i = nline[NLINE_WIDTH-1:0];
        next_cycle();
        refill_i = 1'b0;
    endtask

    task automatic pulse_miss_ready();
        miss_ready_i = 1'b1;
        next_cycle();
        miss_ready_i = 1'b0;
    endtask

    task automatic check_line(input logic [31:0] nline, input logic [31:0] hit);
        check_nline_i = nline[NLINE_WIDTH-1:0];
        @(negedge clk_i);
        check_value("check_hit_o", 32'(check_hit_o), hit);
        next_cycle();
    endtask

    task automatic check_status(input logic [31:0] empty, input logic [31:0] full);
        @(negedge clk_i);
        check_value("empty_o", 32'(empty_o), empty);
        check_value("full_o", 32'(full_o), full);
        next_cycle();
    endtask

    task automatic expect_no_offer(input logic [31:0] count);
        repeat (count) begin
            @(negedge clk_i);
            check_value("pop_valid_o", 32'(pop_valid_o), 32'h0);
            next_cycle();
        end
    endtask

    task automatic run_command(input logic [7:0] cmd, input logic [31:0] f1,
                               input logic [31:0] f2, input logic [31:0] f3,
                               input logic [31:0] f4);
        case (cmd)
            "A": alloc_request(f1, f2, f3, f4);
            "P": pop_and_resolve(f1, f2, f3, f4);
            "F": refill_line(f1);
            "M": pulse_miss_ready();
            "C": check_line(f1, f2);
            "S": check_status(f1, f2);
            "N": expect_no_offer(f1);
            default: begin
                $display("Unknown command '%c' in %s", cmd, STIM_FILE);
                stop_on_error();
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          lines;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;

        rst_ni         = 1'b0;
        check_nline_i  = '0;
        alloc_i        = 1'b0;
        alloc_req_i    = '0;
        alloc_deps_i   = '0;
        pop_ready_i    = 1'b0;
        commit_i       = 1'b0;
        rback_i        = 1'b0;
        rback_deps_i   = '0;
        refill_i       = 1'b0;
        refill_nline_i = '0;
        miss_ready_i   = 1'b0;
        slot_busy      = '0;

        // First pass sizes the timeout
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            stop_on_error();
        end
        lines = 0;
        while ($fgets(line, fd) != 0) begin
            if (is_command(line)) begin
                lines++;
            end
        end
        $fclose(fd);
        cycle_limit = lines * CYCLES_PER_LINE;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_ni = 1'b1;

        fd = $fopen(STIM_FILE, "r");
        while ($fgets(line, fd) != 0) begin
            if (is_command(line)) begin
                f1 = '0;
                f2 = '0;
                f3 = '0;
                f4 = '0;
                void'($sscanf(line, "%c %h %h %h %h", cmd, f1, f2, f3, f4));
                run_command(cmd, f1, f2, f3, f4);
            end
        end
        $fclose(fd);

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: replay_stim.txt
# Hex fields: A addr id hit rdy | P id mode hit rdy (mode 0 commit, 1 rollback)
# F nline | M | C nline hit | S empty full | N cycles without an offer
S 1 0
N 2
A 00001000 01 0 0
A 00001008 02 0 0
A 00001010 03 0 0
A 00002000 04 0 0
C 40 1
P 01 0 0 0
P 02 0 0 0
C 40 1
P 03 0 0 0
C 40 0
P 04 0 0 0
C 80 0
S 1 0
A 00003000 10 1 0
A 00004000 11 0 0
P 11 0 0 0
N 3
F 100
N 2
F c0
P 10 0 0 0
S 1 0
A 00005000 20 0 0
A 00005020 21 0 0
P 20 1 0 1
N 3
C 140 1
M
P 20 0 0 0
P 21 0 0 0
S 1 0
A 00008000 30 0 0
A 00008040 31 0 0
A 00008080 32 0 0
A 000080c0 33 0 0
A 00008100 34 0 0
A 00008140 35 0 0
A 00008180 36 0 0
A 000081c0 37 0 0
S 0 1
P 32 0 0 0
S 0 0
P 33 0 0 0
P 34 0 0 0
P 35 0 0 0
P 36 0 0 0
P 37 0 0 0
P 30 0 0 0
P 31 0 0 0
S 1 0

// File: replay_table.f
replay_pkg.sv
replay_alloc.sv
replay_entries.sv
replay_pop.sv
replay_table.sv
tb_replay_table.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f replay_table.f --top-module tb_replay_table -o sim_replay_table
./obj_dir/sim_replay_table > sim.log 2>&1 || true
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
